/* bench/tb_fft_stim.sv */
`timescale 1ns/1ps

module tb_fft_stim import stim_pkg::*; ();

    localparam int FRAMES_TO_RUN = 4;                           // Frames per channel.
    localparam int WORDS_TO_RUN  = FRAMES_TO_RUN * FRAME_LEN;   // Transfers per channel.
    localparam int PHASE1_WORDS  = 2 * FRAME_LEN;               // Random ready until here.
    localparam int TIMEOUT_CYC   = FRAMES_TO_RUN * FRAME_LEN * 2 * 4 + 200;
    localparam int MAX_IDLE      = 3;                           // Idle cycles that fail.

    logic    clk       = 1'b0;
    logic    resetn    = 1'b0;
    logic    m_valid_0;
    logic    m_ready_0 = 1'b0;
    sample_t m_data_0;
    logic    m_last_0;
    logic    m_valid_1;
    logic    m_ready_1 = 1'b0;
    sample_t m_data_1;
    logic    m_last_1;

    // Model state with one entry per channel.
    sample_t model_mem [0:ROM_DEPTH-1];         // Private copy of the ROM image.
    int      exp_off   [0:N_SRC-1];             // Next expected frame offset.
    int      xfers     [0:N_SRC-1];             // Transfers seen so far.
    int      idle      [0:N_SRC-1];             // Cycles since the last transfer.
    logic    paced     [0:N_SRC-1];             // Rate check armed.
    logic    hold_pend [0:N_SRC-1];             // Stall seen on the last cycle.
    sample_t hold_data [0:N_SRC-1];             // Data presented during the stall.
    logic    hold_last [0:N_SRC-1];             // Last flag presented during the stall.

    logic        first_out = 1'b0;              // First cycle after reset checked.
    logic        all_ready = 1'b0;              // Second phase, ready held high.
    logic        run_done  = 1'b0;              // Both channels finished.
    int          cycles    = 0;                 // Timeout counter.
    integer      seed      = 44;                // Back-pressure seed.
    logic [31:0] rnd;                           // Raw random word.

    fft_stim_top fft_stim_top_i (
        .clk       (clk),
        .resetn    (resetn),
        .m_valid_0 (m_valid_0),
        .m_ready_0 (m_ready_0),
        .m_data_0  (m_data_0),
        .m_last_0  (m_last_0),
        .m_valid_1 (m_valid_1),
        .m_ready_1 (m_ready_1),
        .m_data_1  (m_data_1),
        .m_last_1  (m_last_1)
    );

    always #4 clk = ~clk;                       // 8 ns period.

    // Reports an error in plain words and ends the run.
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail %s: expected %08h, actual %08h", name, exp, act));
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail %s: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    // Returns a channel to the frame start with nothing pending.
    task automatic reset_channel(input logic k);
        exp_off[k]   = 0;
        xfers[k]     = 0;
        idle[k]      = 0;
        paced[k]     = 1'b0;
        hold_pend[k] = 1'b0;
        hold_data[k] = '0;
        hold_last[k] = 1'b0;
    endtask

    // Checks one cycle of one channel at the falling edge.
    task automatic watch_channel(input logic k, input logic valid, input logic ready,
                                 input sample_t data, input logic last);
        sample_t exp_data;
        logic    exp_last;
        addr_t   rom_addr;

        // A stalled word must still be on the bus one cycle later.
        if (hold_pend[k]) begin
            check_sample($sformatf("ch%0d stall data", k), hold_data[k], data);
            check_last($sformatf("ch%0d stall last", k), hold_last[k], last);
        end
        hold_pend[k] = valid & ~ready;
        hold_data[k] = data;
        hold_last[k] = last;

        // Handshake completes at the next rising edge.
        if (valid && ready) begin
            rom_addr = addr_t'(int'(k) * FRAME_LEN + exp_off[k]);
            exp_data = model_mem[rom_addr];
            exp_last = (exp_off[k] == FRAME_LEN - 1);   // Only the final sample.
            check_sample($sformatf("ch%0d data", k), exp_data, data);
            check_last($sformatf("ch%0d last", k), exp_last, last);
            exp_off[k] = (exp_off[k] + 1) % FRAME_LEN;  // Wrap to the frame start.
            xfers[k]   = xfers[k] + 1;
        end

        // Throughput bound is armed by the first transfer with ready held high.
        if (all_ready) begin
            if (valid && ready) begin
                paced[k] = 1'b1;
                idle[k]  = 0;
            end else if (paced[k]) begin
                idle[k] = idle[k] + 1;
                if (idle[k] >= MAX_IDLE) begin
                    stop_on_error($sformatf(
                        "Channel %0d went %0d cycles without a transfer with ready high",
                        k, idle[k]));
                end
            end
        end
    endtask

    // Ready is random in the first phase and held high afterwards.
    always @(posedge clk) begin
        if (all_ready) begin
            m_ready_0 <= 1'b1;
            m_ready_1 <= 1'b1;
        end else begin
            rnd = $random(seed);
            m_ready_0 <= rnd[0];                // About half the cycles.
            m_ready_1 <= rnd[1];
        end
    end

    // Monitor and model run away from the active edge.
    always @(negedge clk) begin
        cycles = cycles + 1;
        if (!run_done && cycles >= TIMEOUT_CYC) begin
            stop_on_error($sformatf(
                "Timeout after %0d cycles, channel 0 moved %0d words, channel 1 moved %0d",
                cycles, xfers[0], xfers[1]));
        end
        if (!resetn) begin
            check_last("reset valid ch0", 1'b0, m_valid_0);
            check_last("reset valid ch1", 1'b0, m_valid_1);
            reset_channel(1'b0);
            reset_channel(1'b1);
        end else if (!run_done) begin
            if (!first_out) begin
                check_last("post reset valid ch0", 1'b0, m_valid_0);
                check_last("post reset valid ch1", 1'b0, m_valid_1);
                first_out = 1'b1;
            end
            watch_channel(1'b0, m_valid_0, m_ready_0, m_data_0, m_last_0);
            watch_channel(1'b1, m_valid_1, m_ready_1, m_data_1, m_last_1);
            if (xfers[0] >= PHASE1_WORDS && xfers[1] >= PHASE1_WORDS) begin
                all_ready = 1'b1;               // Takes effect on the next edge.
            end
            if (xfers[0] >= WORDS_TO_RUN && xfers[1] >= WORDS_TO_RUN) begin
                run_done = 1'b1;
            end
        end
    end

    initial begin
        $readmemh(ROM_FILE, model_mem);
        repeat (10) @(posedge clk);
        resetn <= 1'b1;                         // Released on a rising edge.
        wait (run_done);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* common/stim_pkg.sv */
package stim_pkg;

    // Sample format is 16-bit real in the upper half, 16-bit imaginary below.
    localparam int SAMPLE_W  = 32;              // Width of one complex sample.
    localparam int FRAME_LEN = 32;              // Samples in one frame.
    localparam int N_SRC     = 2;               // Stream sources on the ROM.

    localparam int ROM_DEPTH = N_SRC * FRAME_LEN; // One frame region per source.
    localparam int ADDR_W    = $clog2(ROM_DEPTH); // ROM word address width.
    localparam int OFF_W     = $clog2(FRAME_LEN); // Offset width inside a frame.

    // Hex image shared by the ROM and the bench model.
    localparam string ROM_FILE = "fft_samples.mem";

    typedef logic [SAMPLE_W-1:0] sample_t;     // One ROM or stream word.
    typedef logic [ADDR_W-1:0]   addr_t;       // One ROM word address.

endpackage

/* fft_samples.mem */
// One complex sample per line: real part in the upper 16 bits, imaginary in the lower 16.
// Lines 0 to 31 hold the frame of source 0, lines 32 to 63 the frame of source 1.
00FF40C0
01FE41BF
02FD42BE
03FC43BD
04FB44BC
05FA45BB
06F946BA
07F847B9
08F748B8
09F649B7
0AF54AB6
0BF44BB5
0CF34CB4
0DF24DB3
0EF14EB2
0FF04FB1
10EF50B0
11EE51AF
12ED52AE
13EC53AD
14EB54AC
15EA55AB
16E956AA
17E857A9
18E758A8
19E659A7
1AE55AA6
1BE45BA5
1CE35CA4
1DE25DA3
1EE15EA2
1FE05FA1
20DF60A0
21DE619F
22DD629E
23DC639D
24DB649C
25DA659B
26D9669A
27D86799
28D76898
29D66997
2AD56A96
2BD46B95
2CD36C94
2DD26D93
2ED16E92
2FD06F91
30CF7090
31CE718F
32CD728E
33CC738D
34CB748C
35CA758B
36C9768A
37C87789
38C77888
39C67987
3AC57A86
3BC47B85
3CC37C84
3DC27D83
3EC17E82
3FC07F81

/* list.f */
common/stim_pkg.sv
sample_rom/sample_rom.sv
logic/rom_arbiter.sv
stream_source/stream_source.sv
logic/fft_stim_top.sv
bench/tb_fft_stim.sv

/* logic/fft_stim_top.sv */
`timescale 1ns/1ps

module fft_stim_top import stim_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    output logic    m_valid_0,
    input  logic    m_ready_0,
    output sample_t m_data_0,
    output logic    m_last_0,
    output logic    m_valid_1,
    input  logic    m_ready_1,
    output sample_t m_data_1,
    output logic    m_last_1
);

    logic [N_SRC-1:0] req;                      // Read request level per source.
    logic [N_SRC-1:0] gnt;                      // Grant pulse per source.
    logic [N_SRC-1:0] rvalid;                   // Data return pulse per source.
    addr_t            req_addr_0;
    addr_t            req_addr_1;
    sample_t          rdata;                    // Returned word, shared.
    logic             rd_en;
    addr_t            rd_addr;
    sample_t          rd_data;

    sample_rom sample_rom_i (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    rom_arbiter rom_arbiter_i (
        .clk        (clk),
        .resetn     (resetn),
        .req        (req),
        .req_addr_0 (req_addr_0),
        .req_addr_1 (req_addr_1),
        .gnt        (gnt),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rvalid     (rvalid),
        .rdata      (rdata)
    );

    // Source 0 plays the lower frame region.
    stream_source #(
        .FRAME_BASE (0)
    ) stream_source_0_i (
        .clk      (clk),
        .resetn   (resetn),
        .req      (req[0]),
        .req_addr (req_addr_0),
        .gnt      (gnt[0]),
        .rvalid   (rvalid[0]),
        .rdata    (rdata),
        .m_valid  (m_valid_0),
        .m_ready  (m_ready_0),
        .m_data   (m_data_0),
        .m_last   (m_last_0)
    );

    // Source 1 plays the upper frame region.
    stream_source #(
        .FRAME_BASE (FRAME_LEN)
    ) stream_source_1_i (
        .clk      (clk),
        .resetn   (resetn),
        .req      (req[1]),
        .req_addr (req_addr_1),
        .gnt      (gnt[1]),
        .rvalid   (rvalid[1]),
        .rdata    (rdata),
        .m_valid  (m_valid_1),
        .m_ready  (m_ready_1),
        .m_data   (m_data_1),
        .m_last   (m_last_1)
    );

endmodule

/* logic/rom_arbiter.sv */
`timescale 1ns/1ps

module rom_arbiter import stim_pkg::*; (
    input  logic             clk,
    input  logic             resetn,
    input  logic [N_SRC-1:0] req,
    input  addr_t            req_addr_0,
    input  addr_t            req_addr_1,
    output logic [N_SRC-1:0] gnt,
    output logic             rd_en,
    output addr_t            rd_addr,
    input  sample_t          rd_data,
    output logic [N_SRC-1:0] rvalid,
    output sample_t          rdata
);

    logic last_srv;                             // Source served most recently.
    logic sel;                                  // Source granted this cycle.
    logic rd_pend;                              // A ROM read returns this cycle.
    logic rd_idx;                               // Owner of the returning read.

    // Round robin over two sources.
    always_comb begin
        if (req[0] && req[1]) begin
            sel = ~last_srv;                    // Tie goes to the one that waited.
        end else begin
            sel = req[1];                       // Single requester wins outright.
        end
        gnt = '0;
        if (req != '0) begin
            gnt[sel] = 1'b1;                    // One grant pulse per cycle.
        end
    end

    assign rd_en   = |req;                      // A grant always starts a read.
    assign rd_addr = sel ? req_addr_1 : req_addr_0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            last_srv <= 1'b1;                   // Source 0 takes the first tie.
            rd_pend  <= 1'b0;
        end else begin
            rd_pend <= rd_en;
            if (rd_en) begin
                last_srv <= sel;
            end
        end
    end

    // Remember who asked, so the data goes back to the right source.
    always_ff @(posedge clk) begin
        rd_idx <= sel;
    end

    always_comb begin
        rvalid = '0;
        if (rd_pend) begin
            rvalid[rd_idx] = 1'b1;              // Pulse only toward the owner.
        end
    end

    assign rdata = rd_data;                     // Shared, qualified by rvalid.

endmodule

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root,
# so that the ROM image is found by its relative name.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f list.f --top-module tb_fft_stim -o tb_fft_stim_sim \
    && ./obj_dir/tb_fft_stim_sim > sim.log 2>&1

cat sim.log 2>/dev/null

# The log decides the result, whatever the simulator returned.
grep -qs "Simulation completed successfully" sim.log \
    && echo "run.sh: test passed" \
    || { echo "run.sh: test failed"; exit 1; }

/* sample_rom/sample_rom.sv */
`timescale 1ns/1ps

module sample_rom import stim_pkg::*; (
    input  logic    clk,
    input  logic    rd_en,
    input  addr_t   rd_addr,
    output sample_t rd_data
);

    sample_t mem [0:ROM_DEPTH-1];               // Both frame regions, back to back.

    // Frame contents come from the hex image at elaboration.
    initial begin
        $readmemh(ROM_FILE, mem);
    end

    // Registered read port, one cycle of latency.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];            // Word is valid in the next cycle.
        end
    end

endmodule

/* stream_source/stream_source.sv */
`timescale 1ns/1ps

module stream_source import stim_pkg::*; #(
    parameter int FRAME_BASE = 0                // First ROM word of this frame.
) (
    input  logic    clk,
    input  logic    resetn,
    output logic    req,
    output addr_t   req_addr,
    input  logic    gnt,
    input  logic    rvalid,
    input  sample_t rdata,
    output logic    m_valid,
    input  logic    m_ready,
    output sample_t m_data,
    output logic    m_last
);

    logic             active;                   // Low for the first cycle after reset.
    logic [OFF_W-1:0] offset;                   // Next frame offset to fetch.
    logic             off_end;                  // Offset points at the last sample.
    logic [1:0]       occ;                      // Held words plus the in-flight read.
    logic             inflight;                 // A read was granted last cycle.
    logic             inflight_last;            // Last flag of the in-flight read.
    logic [1:0]       held;                     // Words sitting in the buffer.
    logic             xfer;                     // Output handshake this cycle.
    logic             wr_ptr;                   // Buffer slot for the next return.
    logic             rd_ptr;                   // Buffer slot at the output.
    sample_t          slot_data [0:1];          // Two-entry prefetch buffer.
    logic [1:0]       slot_last;                // Frame-last flag per slot.

    assign off_end  = (offset == OFF_W'(FRAME_LEN - 1));
    assign req_addr = addr_t'(FRAME_BASE) + addr_t'(offset);

    // Returned data is not yet in the buffer while in flight.
    assign held    = occ - {1'b0, inflight};
    assign m_valid = (held != 2'd0);
    assign xfer    = m_valid & m_ready;
    assign m_data  = slot_data[rd_ptr];         // Head slot stays put during a stall.
    assign m_last  = slot_last[rd_ptr];

    // Ask while a slot is free, or will be freed by this cycle's transfer.
    assign req = active & ((occ != 2'd2) | xfer);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            active   <= 1'b0;
            offset   <= '0;
            occ      <= 2'd0;
            inflight <= 1'b0;
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
        end else begin
            active   <= 1'b1;                   // Free running once out of reset.
            inflight <= gnt;                    // Data returns one cycle after grant.
            if (gnt) begin
                if (off_end) begin
                    offset <= '0;               // Wrap to the frame start.
                end else begin
                    offset <= offset + 1'b1;
                end
            end
            // Grant reserves a slot, a transfer releases one.
            occ <= occ + {1'b0, gnt} - {1'b0, xfer};
            if (rvalid) begin
                wr_ptr <= ~wr_ptr;
            end
            if (xfer) begin
                rd_ptr <= ~rd_ptr;
            end
        end
    end

    // Payload path.
    always_ff @(posedge clk) begin
        if (gnt) begin
            inflight_last <= off_end;           // Tag follows the read it belongs to.
        end
        if (rvalid) begin
            slot_data[wr_ptr] <= rdata;         // Never the head slot when one is held.
            slot_last[wr_ptr] <= inflight_last;
        end
    end

endmodule
